/* common/snd_cfg_pkg.sv */
package snd_cfg_pkg;

    // adc word format
    localparam int SAMPLE_W       = 10;
    localparam int SAMPLE_MID     = 512;
    // centred sample carries one extra sign bit
    localparam int CTR_W          = SAMPLE_W + 1;

    // conversion timing, in clk cycles
    localparam int SAMPLE_PERIOD  = 40;
    localparam int SAMPLE_TMR_W   = $clog2(SAMPLE_PERIOD);
    localparam int ADC_LEAD_BITS  = 2;
    localparam int ADC_FRAME_BITS = ADC_LEAD_BITS + SAMPLE_W;
    localparam int ADC_BIT_W      = $clog2(ADC_FRAME_BITS + 1);

    // capture ring and frozen frame geometry
    localparam int RING_DEPTH     = 32;
    localparam int RING_AW        = $clog2(RING_DEPTH);
    localparam int FRAME_LEN      = 16;
    localparam int FRAME_IDX_W    = $clog2(FRAME_LEN);
    localparam int PRE_TRIG       = 8;
    // samples stored after the trigger sample
    localparam int POST_TRIG      = FRAME_LEN - PRE_TRIG - 1;
    localparam int POST_W         = $clog2(POST_TRIG);

    // lag search
    localparam int MAX_LAG        = 4;
    localparam int LAG_W          = 4;
    localparam int ACC_W          = 24;

    // host side
    localparam int DEFAULT_THRESH = 100;
    localparam int RESP_W         = 16;

endpackage

/* common/snd_types_pkg.sv */
package snd_types_pkg;

    import snd_cfg_pkg::*;

    // one adc sample, valid for a single clock
    typedef struct packed {
        logic                valid;
        logic [SAMPLE_W-1:0] value;
    } sample_t;

    // frame read request from the engine to both buffers
    typedef struct packed {
        logic [FRAME_IDX_W-1:0] idx;
        logic                   en;
    } frame_rd_t;

    typedef struct packed {
        logic                    valid;
        logic signed [LAG_W-1:0] lag;
        logic signed [ACC_W-1:0] peak;
    } xcorr_result_t;

    typedef enum logic [3:0] {
        SET_THRESH = 4'h1,
        ARM        = 4'h2,
        READ       = 4'h3
    } cmd_op_e;

    // threshold load layout
    typedef struct packed {
        cmd_op_e             op;
        logic [SAMPLE_W-1:0] thresh;
        logic [1:0]          spare;
    } cmd_thresh_t;

    // readback layout
    typedef struct packed {
        cmd_op_e    op;
        logic [1:0] sel;
        logic [9:0] spare;
    } cmd_read_t;

    // op sits in the same bits in both views
    typedef union packed {
        cmd_thresh_t thresh_view;
        cmd_read_t   read_view;
    } cmd_u;

    typedef logic [RESP_W-1:0] resp_t;

endpackage

/* rtl/adc_spi_rx.sv */
`timescale 1ns/1ps

module adc_spi_rx import snd_cfg_pkg::*, snd_types_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    output logic    cs_n,
    output logic    sclk,
    input  logic    sdo,
    output sample_t sample
);

    logic [SAMPLE_TMR_W-1:0]   tmr;
    logic [ADC_BIT_W-1:0]      bit_cnt;
    logic [SAMPLE_W-1:0]       shreg;
    logic                      shift_en;
    logic                      last_bit;
    logic                      valid_q;
    logic [SAMPLE_W-1:0]       value_q;

    // sample on the clk edge that raises sclk
    assign shift_en = !cs_n && !sclk;
    // sclk high with all bits in, frame ends on this edge
    assign last_bit = !cs_n && sclk && (bit_cnt == ADC_BIT_W'(ADC_FRAME_BITS));

    // free running, starts at reset so both readers stay aligned
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tmr <= '0;
        end else if (tmr == SAMPLE_TMR_W'(SAMPLE_PERIOD - 1)) begin
            tmr <= '0;
        end else begin
            tmr <= tmr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cs_n    <= 1'b1;
            sclk    <= 1'b0;
            bit_cnt <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (tmr == '0) begin
                // open a new conversion
                cs_n    <= 1'b0;
                bit_cnt <= '0;
            end else if (shift_en) begin
                sclk    <= 1'b1;
                bit_cnt <= bit_cnt + 1'b1;
            end else if (!cs_n) begin
                sclk <= 1'b0;
                if (last_bit) begin
                    cs_n    <= 1'b1;
                    valid_q <= 1'b1;
                end
            end
        end
    end

    // leading zeros fall off the top of the word
    always_ff @(posedge clk) begin
        if (shift_en) begin
            shreg <= {shreg[SAMPLE_W-2:0], sdo};
        end
        if (last_bit) begin
            value_q <= shreg;
        end
    end

    assign sample.valid = valid_q;
    assign sample.value = value_q;

endmodule

/* capture/trigger_detect.sv */
`timescale 1ns/1ps

module trigger_detect import snd_cfg_pkg::*, snd_types_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  sample_t             sample,
    input  logic [SAMPLE_W-1:0] threshold,
    input  logic                arm_pulse,
    output logic                trig,
    output logic [SAMPLE_W-1:0] trig_value
);

    logic signed [CTR_W-1:0] centred;
    logic [SAMPLE_W-1:0]     mag;
    logic                    armed;
    logic                    fire;

    // remove the mid-scale offset
    assign centred = $signed({1'b0, sample.value}) - CTR_W'(SAMPLE_MID);
    // magnitude, -512 wraps to 512 in the low bits
    assign mag  = centred[CTR_W-1] ? SAMPLE_W'(-centred) : SAMPLE_W'(centred);
    // strictly above threshold
    assign fire = sample.valid && armed && (mag > threshold);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            armed      <= 1'b1;
            trig       <= 1'b0;
            trig_value <= '0;
        end else begin
            trig <= fire;
            // single shot until the host re-arms
            if (arm_pulse) begin
                armed <= 1'b1;
            end else if (fire) begin
                armed <= 1'b0;
            end
            if (fire) begin
                trig_value <= sample.value;
            end
        end
    end

endmodule

/* capture/capture_buffer.sv */
`timescale 1ns/1ps

module capture_buffer import snd_cfg_pkg::*, snd_types_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  sample_t             sample,
    input  logic                trig,
    input  logic                arm_pulse,
    input  frame_rd_t           rd,
    output logic [SAMPLE_W-1:0] rd_data,
    output logic                frozen
);

    logic [SAMPLE_W-1:0] mem [RING_DEPTH];
    logic [RING_AW-1:0]  wr_ptr;
    logic [RING_AW-1:0]  trig_slot;
    logic [RING_AW-1:0]  rd_addr;
    logic [POST_W-1:0]   post_cnt;
    logic                triggered;
    logic                wr_en;

    // writes stop once the frame is frozen
    assign wr_en   = sample.valid && !frozen;
    // frame index 0 is PRE_TRIG slots before the trigger sample
    assign rd_addr = trig_slot - RING_AW'(PRE_TRIG) + RING_AW'(rd.idx);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= sample.value;
        end
        // one clock read latency
        if (rd.en) begin
            rd_data <= mem[rd_addr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            trig_slot <= '0;
            post_cnt  <= '0;
            triggered <= 1'b0;
            frozen    <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (arm_pulse) begin
                // back to collecting
                triggered <= 1'b0;
                frozen    <= 1'b0;
                post_cnt  <= '0;
            end else if (trig && !triggered && !frozen) begin
                // trig lags valid by one clock, so the last write is the trigger sample
                triggered <= 1'b1;
                trig_slot <= wr_ptr - 1'b1;
                post_cnt  <= '0;
            end else if (triggered && wr_en) begin
                post_cnt <= post_cnt + 1'b1;
                // seventh sample after the trigger closes the frame
                if (post_cnt == POST_W'(POST_TRIG - 1)) begin
                    triggered <= 1'b0;
                    frozen    <= 1'b1;
                end
            end
        end
    end

endmodule

/* xcorr/xcorr_engine.sv */
`timescale 1ns/1ps

module xcorr_engine import snd_cfg_pkg::*, snd_types_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                frozen_x,
    input  logic                frozen_y,
    output frame_rd_t           rd,
    input  logic [SAMPLE_W-1:0] data_x,
    input  logic [SAMPLE_W-1:0] data_y,
    input  logic                arm_pulse,
    output xcorr_result_t       result
);

    typedef enum logic [2:0] {IDLE, LOAD, RUN, CMP, DONE} state_e;

    state_e                   state;
    logic [FRAME_IDX_W:0]     ld_cnt;
    logic                     rd_pend;
    logic [FRAME_IDX_W-1:0]   rd_idx_q;
    logic signed [CTR_W-1:0]  x_buf [FRAME_LEN];
    logic signed [CTR_W-1:0]  y_buf [FRAME_LEN];
    logic signed [LAG_W-1:0]  lag;
    logic signed [LAG_W-1:0]  next_lag;
    logic signed [LAG_W-1:0]  best_lag;
    logic [FRAME_IDX_W-1:0]   i_idx;
    logic [FRAME_IDX_W-1:0]   i_end;
    logic [FRAME_IDX_W-1:0]   y_idx;
    logic [FRAME_IDX_W-1:0]   next_start;
    logic signed [2*CTR_W-1:0] prod;
    logic signed [ACC_W-1:0]  acc;
    logic signed [ACC_W-1:0]  best_sum;

    // same index to both buffers while loading
    assign rd.en  = (state == LOAD) && !ld_cnt[FRAME_IDX_W];
    assign rd.idx = ld_cnt[FRAME_IDX_W-1:0];

    // overlap window for the current and next lag
    assign next_lag   = lag + LAG_W'(1);
    assign next_start = next_lag[LAG_W-1] ? FRAME_IDX_W'(-next_lag) : '0;
    assign i_end      = lag[LAG_W-1] ? FRAME_IDX_W'(FRAME_LEN - 1)
                                     : FRAME_IDX_W'(FRAME_LEN - 1) - FRAME_IDX_W'(lag);
    // wraps mod 16, always inside the window
    assign y_idx = i_idx + FRAME_IDX_W'(lag);
    // the single multiplier
    assign prod  = x_buf[i_idx] * y_buf[y_idx];

    // local copies, centred on the way in
    always_ff @(posedge clk) begin
        rd_idx_q <= rd.idx;
        if (rd_pend) begin
            x_buf[rd_idx_q] <= $signed({1'b0, data_x}) - CTR_W'(SAMPLE_MID);
            y_buf[rd_idx_q] <= $signed({1'b0, data_y}) - CTR_W'(SAMPLE_MID);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            ld_cnt   <= '0;
            rd_pend  <= 1'b0;
            lag      <= '0;
            i_idx    <= '0;
            acc      <= '0;
            best_lag <= '0;
            best_sum <= '0;
        end else begin
            rd_pend <= rd.en;
            if (arm_pulse) begin
                // new capture starts with an empty result
                state    <= IDLE;
                best_lag <= '0;
                best_sum <= '0;
            end else begin
                case (state)
                    IDLE: begin
                        if (frozen_x && frozen_y) begin
                            state  <= LOAD;
                            ld_cnt <= '0;
                        end
                    end
                    LOAD: begin
                        if (ld_cnt[FRAME_IDX_W]) begin
                            // last pair lands on this edge
                            state    <= RUN;
                            lag      <= -LAG_W'(MAX_LAG);
                            i_idx    <= FRAME_IDX_W'(MAX_LAG);
                            acc      <= '0;
                            best_sum <= {1'b1, {(ACC_W-1){1'b0}}};
                        end else begin
                            ld_cnt <= ld_cnt + 1'b1;
                        end
                    end
                    RUN: begin
                        // one product per clock
                        acc <= acc + prod;
                        if (i_idx == i_end) begin
                            state <= CMP;
                        end else begin
                            i_idx <= i_idx + 1'b1;
                        end
                    end
                    CMP: begin
                        // strict compare keeps the more negative lag on a tie
                        if (acc > best_sum) begin
                            best_sum <= acc;
                            best_lag <= lag;
                        end
                        if (lag == LAG_W'(MAX_LAG)) begin
                            state <= DONE;
                        end else begin
                            lag   <= next_lag;
                            i_idx <= next_start;
                            acc   <= '0;
                            state <= RUN;
                        end
                    end
                    default: begin
                        // DONE holds the result until re-armed
                        state <= DONE;
                    end
                endcase
            end
        end
    end

    assign result.valid = (state == DONE);
    assign result.lag   = best_lag;
    assign result.peak  = best_sum;

endmodule

/* rtl/host_cmd.sv */
`timescale 1ns/1ps

module host_cmd import snd_cfg_pkg::*, snd_types_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cmd_req,
    input  cmd_u                cmd,
    output logic                cmd_ack,
    output resp_t               resp,
    output logic [SAMPLE_W-1:0] threshold,
    output logic                arm_pulse,
    input  logic [SAMPLE_W-1:0] trig_value,
    input  logic                frozen_x,
    input  xcorr_result_t       result
);

    typedef enum logic [1:0] {H_IDLE, H_EXEC, H_ACK} hstate_e;

    hstate_e state;
    resp_t   resp_next;

    // readback mux, zero for anything but READ
    always_comb begin
        resp_next = '0;
        if (cmd.read_view.op == READ) begin
            case (cmd.read_view.sel)
                2'd0: resp_next = {result.valid, frozen_x && !result.valid, 6'b0,
                                   {(8-LAG_W){result.lag[LAG_W-1]}}, result.lag};
                2'd1: resp_next = RESP_W'(trig_value);
                2'd2: resp_next = result.peak[ACC_W-1 -: RESP_W];
                default: resp_next = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= H_IDLE;
            cmd_ack   <= 1'b0;
            resp      <= '0;
            threshold <= SAMPLE_W'(DEFAULT_THRESH);
            arm_pulse <= 1'b0;
        end else begin
            arm_pulse <= 1'b0;
            case (state)
                H_IDLE: begin
                    if (cmd_req) begin
                        state <= H_EXEC;
                    end
                end
                H_EXEC: begin
                    // act once, then hold ack with resp stable
                    resp    <= resp_next;
                    cmd_ack <= 1'b1;
                    state   <= H_ACK;
                    if (cmd.thresh_view.op == SET_THRESH) begin
                        threshold <= cmd.thresh_view.thresh;
                    end
                    if (cmd.thresh_view.op == ARM) begin
                        arm_pulse <= 1'b1;
                    end
                end
                default: begin
                    // wait for the host to drop req
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        state   <= H_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

/* rtl/sound_locator_top.sv */
`timescale 1ns/1ps

module sound_locator_top import snd_cfg_pkg::*, snd_types_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    output logic  adc_x_cs_n,
    output logic  adc_x_sclk,
    input  logic  adc_x_sdo,
    output logic  adc_y_cs_n,
    output logic  adc_y_sclk,
    input  logic  adc_y_sdo,
    input  logic  cmd_req,
    input  cmd_u  cmd,
    output logic  cmd_ack,
    output resp_t resp
);

    sample_t             smp_x;
    sample_t             smp_y;
    logic                trig;
    logic [SAMPLE_W-1:0] trig_value;
    logic [SAMPLE_W-1:0] threshold;
    logic                arm_pulse;
    logic                frozen_x;
    logic                frozen_y;
    frame_rd_t           frame_rd;
    logic [SAMPLE_W-1:0] rd_data_x;
    logic [SAMPLE_W-1:0] rd_data_y;
    xcorr_result_t       result;

    // readers run in lockstep from reset
    adc_spi_rx i_adc_x (
        .clk    (clk),
        .rst_n  (rst_n),
        .cs_n   (adc_x_cs_n),
        .sclk   (adc_x_sclk),
        .sdo    (adc_x_sdo),
        .sample (smp_x)
    );

    adc_spi_rx i_adc_y (
        .clk    (clk),
        .rst_n  (rst_n),
        .cs_n   (adc_y_cs_n),
        .sclk   (adc_y_sclk),
        .sdo    (adc_y_sdo),
        .sample (smp_y)
    );

    // trigger watches channel x only
    trigger_detect i_trigger (
        .clk        (clk),
        .rst_n      (rst_n),
        .sample     (smp_x),
        .threshold  (threshold),
        .arm_pulse  (arm_pulse),
        .trig       (trig),
        .trig_value (trig_value)
    );

    capture_buffer i_capture_x (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample    (smp_x),
        .trig      (trig),
        .arm_pulse (arm_pulse),
        .rd        (frame_rd),
        .rd_data   (rd_data_x),
        .frozen    (frozen_x)
    );

    capture_buffer i_capture_y (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample    (smp_y),
        .trig      (trig),
        .arm_pulse (arm_pulse),
        .rd        (frame_rd),
        .rd_data   (rd_data_y),
        .frozen    (frozen_y)
    );

    xcorr_engine i_xcorr (
        .clk       (clk),
        .rst_n     (rst_n),
        .frozen_x  (frozen_x),
        .frozen_y  (frozen_y),
        .rd        (frame_rd),
        .data_x    (rd_data_x),
        .data_y    (rd_data_y),
        .arm_pulse (arm_pulse),
        .result    (result)
    );

    host_cmd i_host (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_req    (cmd_req),
        .cmd        (cmd),
        .cmd_ack    (cmd_ack),
        .resp       (resp),
        .threshold  (threshold),
        .arm_pulse  (arm_pulse),
        .trig_value (trig_value),
        .frozen_x   (frozen_x),
        .result     (result)
    );

endmodule

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk
);

    // half of the 40 ns period
    localparam int HALF_NS = 20;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_NS clk = ~clk;
        end
    end

endmodule

/* verif/tb_sound_locator.sv */
`timescale 1ns/1ps

module tb_sound_locator
    import snd_cfg_pkg::*, snd_types_pkg::*;
();

    // tests need about 105 sample periods, 150 leaves margin
    localparam int TIMEOUT_CYCLES = 150 * SAMPLE_PERIOD;
    localparam int ACK_LIMIT      = 20;
    localparam int POLL_LIMIT     = 100;

    logic  clk;
    logic  rst_n;
    logic  adc_x_cs_n;
    logic  adc_x_sclk;
    logic  adc_x_sdo;
    logic  adc_y_cs_n;
    logic  adc_y_sclk;
    logic  adc_y_sdo;
    logic  cmd_req;
    cmd_u  cmd;
    logic  cmd_ack;
    resp_t resp;

    // values waiting to be shifted out, mid-scale when empty
    logic [SAMPLE_W-1:0] x_q [$];
    logic [SAMPLE_W-1:0] y_q [$];
    // raw sample sequences of the current event
    int ev_x [$];
    int ev_y [$];

    int seed;
    int cycle;
    int cur_thresh;
    int err_mismatch;
    int err_other;

    // expected result of the latest event
    logic signed [LAG_W-1:0] exp_lag;
    int                      exp_peak;
    logic [SAMPLE_W-1:0]     exp_trig;

    tb_clk_gen i_clk_gen (
        .clk (clk)
    );

    sound_locator_top i_sound_locator_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .adc_x_cs_n (adc_x_cs_n),
        .adc_x_sclk (adc_x_sclk),
        .adc_x_sdo  (adc_x_sdo),
        .adc_y_cs_n (adc_y_cs_n),
        .adc_y_sclk (adc_y_sclk),
        .adc_y_sdo  (adc_y_sdo),
        .cmd_req    (cmd_req),
        .cmd        (cmd),
        .cmd_ack    (cmd_ack),
        .resp       (resp)
    );

    task automatic check_resp(input string name, input resp_t got, input resp_t exp);
        if (got !== exp) begin
            err_mismatch++;
            $display("MISMATCH at %0t: %s got 0x%h expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic check_lag(input string name, input logic signed [LAG_W-1:0] got,
                             input logic signed [LAG_W-1:0] exp);
        if (got !== exp) begin
            err_mismatch++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_sample(input string name, input logic [SAMPLE_W-1:0] got,
                                input logic [SAMPLE_W-1:0] exp);
        if (got !== exp) begin
            err_mismatch++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            err_mismatch++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic note_failure(input string what);
        err_other++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    // serial adc models, new bit 2 ns after each sclk fall
    task automatic adc_x_model();
        logic [ADC_FRAME_BITS-1:0] word;
        int b;
        adc_x_sdo = 1'b0;
        forever begin
            @(negedge adc_x_cs_n);
            #2;
            if (x_q.size() > 0) begin
                word = ADC_FRAME_BITS'(x_q.pop_front());
            end else begin
                word = ADC_FRAME_BITS'(SAMPLE_MID);
            end
            // leading zeros then value, msb first
            for (b = ADC_FRAME_BITS - 1; b >= 0; b--) begin
                adc_x_sdo = word[b];
                @(negedge adc_x_sclk);
                #2;
            end
        end
    endtask

    task automatic adc_y_model();
        logic [ADC_FRAME_BITS-1:0] word;
        int b;
        adc_y_sdo = 1'b0;
        forever begin
            @(negedge adc_y_cs_n);
            #2;
            if (y_q.size() > 0) begin
                word = ADC_FRAME_BITS'(y_q.pop_front());
            end else begin
                word = ADC_FRAME_BITS'(SAMPLE_MID);
            end
            for (b = ADC_FRAME_BITS - 1; b >= 0; b--) begin
                adc_y_sdo = word[b];
                @(negedge adc_y_sclk);
                #2;
            end
        end
    endtask

    // four-phase req/ack, resp taken while ack is high
    task automatic handshake(input cmd_u c, output resp_t r);
        int wait_cnt;
        @(posedge clk);
        #2;
        cmd     = c;
        cmd_req = 1'b1;
        wait_cnt = 0;
        while (cmd_ack !== 1'b1 && wait_cnt < ACK_LIMIT) begin
            @(posedge clk);
            #2;
            wait_cnt++;
        end
        if (cmd_ack !== 1'b1) begin
            note_failure("host port never raised cmd_ack");
        end
        r       = resp;
        cmd_req = 1'b0;
        wait_cnt = 0;
        while (cmd_ack !== 1'b0 && wait_cnt < ACK_LIMIT) begin
            @(posedge clk);
            #2;
            wait_cnt++;
        end
        if (cmd_ack !== 1'b0) begin
            note_failure("host port kept cmd_ack high after cmd_req fell");
        end
    endtask

    task automatic host_write(input cmd_u c);
        resp_t r;
        handshake(c, r);
    endtask

    task automatic host_read(input logic [1:0] sel, output resp_t r);
        cmd_u c;
        c = '0;
        c.read_view.op  = READ;
        c.read_view.sel = sel;
        handshake(c, r);
    endtask

    task automatic set_threshold(input int th);
        cmd_u c;
        c = '0;
        c.thresh_view.op     = SET_THRESH;
        c.thresh_view.thresh = SAMPLE_W'(th);
        host_write(c);
        cur_thresh = th;
    endtask

    task automatic arm_capture();
        cmd_u c;
        c = '0;
        c.thresh_view.op = ARM;
        host_write(c);
    endtask

    // valid at 15, busy at 14, lag sign-extended into the low byte
    function automatic resp_t status_word(input logic valid, input logic busy,
                                          input logic signed [LAG_W-1:0] lag);
        resp_t w;
        int    l;
        l       = lag;
        w       = '0;
        w[15]   = valid;
        w[14]   = busy;
        w[7:0]  = l[7:0];
        return w;
    endfunction

    // until the last queued sample has passed the trigger
    task automatic wait_drained();
        while (x_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge adc_x_cs_n);
        repeat (3) @(posedge clk);
    endtask

    // frame around the first loud x sample, then best lag over -4..4
    task automatic predict();
        int xf [FRAME_LEN];
        int yf [FRAME_LEN];
        int t;
        int k;
        int i;
        int d;
        int l;
        int sum;
        int best;
        t = -1;
        for (k = 0; k < ev_x.size(); k++) begin
            d = ev_x[k] - SAMPLE_MID;
            if (d < 0) begin
                d = -d;
            end
            if (t < 0 && d > cur_thresh) begin
                t = k;
            end
        end
        if (t < PRE_TRIG) begin
            note_failure("event sequence lacks a loud sample after the pre-trigger part");
            t = PRE_TRIG;
        end
        for (i = 0; i < FRAME_LEN; i++) begin
            k = t - PRE_TRIG + i;
            // past the end the adc model sends mid-scale
            xf[i] = (k < ev_x.size()) ? ev_x[k] - SAMPLE_MID : 0;
            yf[i] = (k < ev_y.size()) ? ev_y[k] - SAMPLE_MID : 0;
        end
        best     = -MAX_LAG;
        exp_peak = 0;
        for (l = -MAX_LAG; l <= MAX_LAG; l++) begin
            sum = 0;
            for (i = 0; i < FRAME_LEN; i++) begin
                if (i + l >= 0 && i + l < FRAME_LEN) begin
                    sum += xf[i] * yf[i + l];
                end
            end
            // strictly larger, so ties stay with the earlier lag
            if (l == -MAX_LAG || sum > exp_peak) begin
                exp_peak = sum;
                best     = l;
            end
        end
        exp_lag  = best[LAG_W-1:0];
        k        = ev_x[t];
        exp_trig = k[SAMPLE_W-1:0];
    endtask

    // y is the x waveform delayed by delay samples, pulse at frame index 8
    task automatic build_shifted(input int delay);
        int w [FRAME_LEN + 2*MAX_LAG];
        int k;
        for (k = 0; k < FRAME_LEN + 2*MAX_LAG; k++) begin
            w[k] = SAMPLE_MID + ($random(seed) % 20);
        end
        w[PRE_TRIG + MAX_LAG]     += 300;
        w[PRE_TRIG + MAX_LAG + 1] -= 220;
        w[PRE_TRIG + MAX_LAG + 2] += 150;
        w[PRE_TRIG + MAX_LAG + 3] -= 90;
        w[PRE_TRIG + MAX_LAG + 4] += 40;
        ev_x.delete();
        ev_y.delete();
        for (k = 0; k < FRAME_LEN; k++) begin
            ev_x.push_back(w[k + MAX_LAG]);
            ev_y.push_back(w[k + MAX_LAG - delay]);
        end
    endtask

    // single x pulse, two equal y pulses mirrored around it
    task automatic build_symmetric(input int offset);
        int k;
        ev_x.delete();
        ev_y.delete();
        for (k = 0; k < FRAME_LEN; k++) begin
            ev_x.push_back(SAMPLE_MID);
            ev_y.push_back(SAMPLE_MID);
        end
        ev_x[PRE_TRIG]          = SAMPLE_MID + 250;
        ev_y[PRE_TRIG - offset] = SAMPLE_MID + 200;
        ev_y[PRE_TRIG + offset] = SAMPLE_MID + 200;
    endtask

    // arm, play the sequence, poll for the result and check all readbacks
    task automatic run_event(input string label);
        resp_t r;
        int    polls;
        int    k;
        predict();
        arm_capture();
        for (k = 0; k < ev_x.size(); k++) begin
            x_q.push_back(SAMPLE_W'(ev_x[k]));
            y_q.push_back(SAMPLE_W'(ev_y[k]));
        end
        wait_drained();
        // frames just frozen and the engine still working
        host_read(2'd0, r);
        check_resp({label, " busy status"}, r, status_word(1'b0, 1'b1, '0));
        polls = 0;
        while (r[15] !== 1'b1 && polls < POLL_LIMIT) begin
            host_read(2'd0, r);
            polls++;
        end
        if (r[15] !== 1'b1) begin
            note_failure({label, ": correlation result never became valid"});
        end else begin
            check_resp({label, " status"}, r, status_word(1'b1, 1'b0, exp_lag));
            check_lag({label, " lag"}, r[LAG_W-1:0], exp_lag);
            host_read(2'd1, r);
            check_sample({label, " trigger value"}, r[SAMPLE_W-1:0], exp_trig);
            host_read(2'd2, r);
            check_resp({label, " peak"}, r, exp_peak[ACC_W-1 -: RESP_W]);
        end
    endtask

    task automatic test_idle();
        resp_t r;
        int    c0;
        host_read(2'd0, r);
        check_resp("idle status", r, '0);
        @(negedge adc_x_cs_n);
        c0 = cycle;
        @(negedge adc_x_cs_n);
        check_count("cs_n period in clocks", cycle - c0, SAMPLE_PERIOD);
        #1;
        if (adc_y_cs_n !== adc_x_cs_n) begin
            note_failure("channel y conversion is not aligned with channel x");
        end
    endtask

    task automatic test_threshold();
        resp_t r;
        int    k;
        // quiet noise then a sample exactly at the threshold
        for (k = 0; k < 10; k++) begin
            x_q.push_back(SAMPLE_W'(SAMPLE_MID + ($random(seed) % 90)));
            y_q.push_back(SAMPLE_W'(SAMPLE_MID));
        end
        x_q.push_back(SAMPLE_W'(SAMPLE_MID + DEFAULT_THRESH));
        y_q.push_back(SAMPLE_W'(SAMPLE_MID));
        wait_drained();
        host_read(2'd1, r);
        check_sample("trigger value at threshold", r[SAMPLE_W-1:0], '0);
        host_read(2'd0, r);
        check_resp("status at threshold", r, '0);
        // lower threshold, 80 above mid must fire
        set_threshold(60);
        x_q.push_back(SAMPLE_W'(SAMPLE_MID + 80));
        y_q.push_back(SAMPLE_W'(SAMPLE_MID));
        wait_drained();
        host_read(2'd1, r);
        check_sample("trigger value above threshold", r[SAMPLE_W-1:0],
                     SAMPLE_W'(SAMPLE_MID + 80));
    endtask

    task automatic test_positive_lag();
        set_threshold(DEFAULT_THRESH);
        build_shifted(3);
        run_event("delay +3");
    endtask

    task automatic test_negative_lag();
        build_shifted(-2);
        run_event("lead 2");
        build_symmetric(3);
        run_event("tie");
    endtask

    task automatic test_rearm();
        resp_t r;
        arm_capture();
        host_read(2'd0, r);
        check_resp("status after arm", r, '0);
        build_shifted(1);
        run_event("re-armed delay +1");
        // trigger stays disarmed, old result must remain
        x_q.push_back(SAMPLE_W'(900));
        y_q.push_back(SAMPLE_W'(100));
        wait_drained();
        host_read(2'd0, r);
        check_resp("status without arm", r, status_word(1'b1, 1'b0, exp_lag));
        host_read(2'd1, r);
        check_sample("trigger value without arm", r[SAMPLE_W-1:0], exp_trig);
        host_read(2'd2, r);
        check_resp("peak without arm", r, exp_peak[ACC_W-1 -: RESP_W]);
    endtask

    initial begin
        adc_x_model();
    end

    initial begin
        adc_y_model();
    end

    // run limit
    initial begin
        cycle = 0;
        while (cycle < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle++;
        end
        $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("errors: %0d mismatches, %0d other failures", err_mismatch, err_other + 1);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        seed         = 66;
        cur_thresh   = DEFAULT_THRESH;
        err_mismatch = 0;
        err_other    = 0;
        rst_n        = 1'b0;
        cmd_req      = 1'b0;
        cmd          = '0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_idle();
        test_threshold();
        test_positive_lag();
        test_negative_lag();
        test_rearm();
        $display("errors: %0d mismatches, %0d other failures", err_mismatch, err_other);
        if (err_mismatch == 0 && err_other == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* sound_locator.f */
common/snd_cfg_pkg.sv
common/snd_types_pkg.sv
rtl/adc_spi_rx.sv
capture/trigger_detect.sv
capture/capture_buffer.sv
xcorr/xcorr_engine.sv
rtl/host_cmd.sv
rtl/sound_locator_top.sv
verif/tb_clk_gen.sv
verif/tb_sound_locator.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_sound_locator -f sound_locator.f

out=$(./obj_dir/Vtb_sound_locator)
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
exit 1
